/* hint_pkg.sv */
/*
 * hint decode package
 * sizes of the encoded hint string, memory layout constants and the
 * shared types of the hint decode subsystem
 */

package hint_pkg;

    // ------------------------------------------------------------------
    // signature format sizes
    // ------------------------------------------------------------------

    // total number of hint indices that the encoding may carry
    localparam int hint_omega = 75;

    // number of polynomials in the hint vector
    localparam int hint_k = 8;

    // coefficients in one polynomial
    localparam int hint_n = 256;

    // the encoded string is the index bytes followed by one count per polynomial
    localparam int hint_bytes = hint_omega + hint_k;

    // ------------------------------------------------------------------
    // memory layout
    // ------------------------------------------------------------------

    // every coefficient is stored as a 24 bit value
    localparam int coeff_width = 24;

    // word address width of the destination memory
    localparam int mem_addr_width = 14;

    // four coefficients per word, so a polynomial spans 64 words
    localparam int words_per_poly = hint_n / 4;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    // one byte of the encoding, either a hint index or a cumulative count
    typedef logic [7:0] byte_t;

    // polynomial number inside the hint vector
    typedef logic [2:0] poly_idx_t;

    // memory word address
    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // memory word holding four coefficients, coefficient 0 in the low bits
    typedef logic [4*coeff_width-1:0] mem_word_t;

    // one bit per coefficient of the current polynomial
    typedef logic [hint_n-1:0] bitmap_t;

    // lane valid mask of a four index group
    typedef logic [3:0] group_mask_t;

    // sequencer FSM states
    typedef enum logic [2:0] {
        idle,
        load_count,
        read_hints,
        write_poly,
        clear,
        finish
    } seq_state_t;

endpackage

/* hint_seq_if.sv */
/*
 * hint sequencer interface
 * carries index groups and per-polynomial control from the sequencer
 * to the bitmap builder and the Wishbone writer
 */

interface hint_seq_if import hint_pkg::*; ();

    // index groups, up to four hint indices per cycle
    logic          group_valid;
    byte_t [3:0]   group_idx;
    group_mask_t   group_mask;

    // clears the bitmap and the ordering tracker for the next polynomial
    logic          poly_start;

    // bitmap builder results
    logic          order_error;
    bitmap_t       bitmap;

    // write pass handshake between the sequencer and the writer
    logic          write_go;
    mem_addr_t     write_base;
    logic          write_done;

    modport seq (
        output group_valid, group_idx, group_mask, poly_start,
        output write_go, write_base,
        input  order_error, write_done
    );

    // bitmap builder side, takes the groups and returns the hint vector
    modport builder (
        input  group_valid, group_idx, group_mask, poly_start,
        output order_error, bitmap
    );

    modport writer (
        input  write_go, write_base, bitmap,
        output write_done
    );

endinterface

/* hint_sequencer.sv */
/*
 * hint decode sequencer
 * walks the cumulative counts, checks them, streams the index bytes of
 * each polynomial in groups of four and starts one write pass per polynomial
 */

module hint_sequencer import hint_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    start,
    input  byte_t [hint_bytes-1:0]  encoded_h,
    input  mem_addr_t               dest_base_addr,
    hint_seq_if.seq                 seq,
    output logic                    done,
    output logic                    error
);

    seq_state_t  state;
    poly_idx_t   poly;

    // cumulative count of the previous polynomial and hints still to send
    byte_t       prev_cnt;
    byte_t       remain;

    // read pointer into the index bytes
    logic [6:0]  rd_ptr;

    // set on entry to write_poly, the bitmap needs one more cycle to settle
    logic        go_wait;

    logic [6:0]  count_sel;
    byte_t       count_now;
    logic        count_err;
    logic [6:0]  lane_ptr [4];
    group_mask_t lane_mask;

    // ------------------------------------------------------------------
    // count decode
    // ------------------------------------------------------------------

    // the count bytes sit right after the omega index bytes
    assign count_sel = 7'(hint_omega) + 7'(poly);
    assign count_now = encoded_h[count_sel];

    // a count may never drop and never pass the total hint budget
    assign count_err = (count_now < prev_cnt) || (count_now > byte_t'(hint_omega));

    // ------------------------------------------------------------------
    // group building
    // ------------------------------------------------------------------

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            lane_ptr[j] = rd_ptr + 7'(j);
        end
    end

    // the last group of a polynomial may only be partly filled
    always_comb begin
        case (remain)
            8'd1:    lane_mask = 4'b0001;
            8'd2:    lane_mask = 4'b0011;
            8'd3:    lane_mask = 4'b0111;
            default: lane_mask = 4'b1111;
        endcase
    end

    // the bitmap and the ordering tracker are cleared in clear
    assign seq.poly_start = (state == clear);

    // done is high for the single cycle spent in finish
    assign done = (state == finish);

    // ------------------------------------------------------------------
    // FSM and control registers
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= idle;
            poly            <= '0;
            prev_cnt        <= '0;
            remain          <= '0;
            rd_ptr          <= '0;
            go_wait         <= 1'b0;
            seq.group_valid <= 1'b0;
            seq.write_go    <= 1'b0;
            error           <= 1'b0;
        end else if (zeroize) begin
            state           <= idle;
            poly            <= '0;
            prev_cnt        <= '0;
            remain          <= '0;
            rd_ptr          <= '0;
            go_wait         <= 1'b0;
            seq.group_valid <= 1'b0;
            seq.write_go    <= 1'b0;
            error           <= 1'b0;
        end else begin
            // both strobes are single-cycle unless set again below
            seq.group_valid <= 1'b0;
            seq.write_go    <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        poly     <= '0;
                        prev_cnt <= '0;
                        error    <= 1'b0;
                        state    <= clear;
                    end
                end
                clear: begin
                    state <= load_count;
                end
                load_count: begin
                    // a bad count stops before any word of this polynomial is written
                    if (count_err) begin
                        error <= 1'b1;
                        state <= finish;
                    end else begin
                        prev_cnt <= count_now;
                        remain   <= count_now - prev_cnt;
                        rd_ptr   <= prev_cnt[6:0];
                        state    <= read_hints;
                    end
                end
                read_hints: begin
                    // one group goes out per cycle while the pointer advances
                    if (remain != '0) begin
                        seq.group_valid <= 1'b1;
                        rd_ptr          <= rd_ptr + 7'd4;
                        remain          <= (remain > 8'd4) ? remain - 8'd4 : '0;
                    end else begin
                        go_wait <= 1'b1;
                        state   <= write_poly;
                    end
                end
                write_poly: begin
                    if (go_wait) begin
                        // the last group has landed, so order_error is final here
                        go_wait <= 1'b0;
                        if (seq.order_error) begin
                            error <= 1'b1;
                            state <= finish;
                        end else begin
                            seq.write_go <= 1'b1;
                        end
                    end else if (seq.write_done) begin
                        if (poly == poly_idx_t'(hint_k - 1)) begin
                            state <= finish;
                        end else begin
                            poly  <= poly + 3'd1;
                            state <= clear;
                        end
                    end
                end
                finish: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // group and write payload
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (state == read_hints) begin
            for (int j = 0; j < 4; j++) begin
                seq.group_idx[j] <= encoded_h[lane_ptr[j]];
            end
            seq.group_mask <= lane_mask;
        end
        // polynomial p starts 64 words further on than polynomial p-1
        if (state == write_poly && go_wait) begin
            seq.write_base <= dest_base_addr + mem_addr_t'(poly) * mem_addr_t'(words_per_poly);
        end
    end

endmodule

/* hint_bitmap.sv */
/*
 * hint bitmap builder
 * sets one bit per received hint index and checks that the indices of
 * a polynomial are strictly increasing
 */

module hint_bitmap import hint_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          zeroize,
    hint_seq_if.builder   bmp
);

    // last index seen in the current polynomial and whether there was one
    byte_t   last_idx;
    logic    last_seen;

    // combinational view of the incoming group
    bitmap_t set_vec;
    byte_t   chk_last;
    logic    chk_seen;
    logic    chk_bad;

    // ------------------------------------------------------------------
    // group evaluation
    // ------------------------------------------------------------------

    // lanes are filled from lane 0 upward, so each lane compares to the one before it
    // and lane 0 compares to the tail of the previous group
    always_comb begin
        set_vec  = '0;
        chk_last = last_idx;
        chk_seen = last_seen;
        chk_bad  = 1'b0;
        for (int j = 0; j < 4; j++) begin
            if (bmp.group_mask[j]) begin
                set_vec[bmp.group_idx[j]] = 1'b1;
                // a repeated index is as bad as a decreasing one
                if (chk_seen && (bmp.group_idx[j] <= chk_last)) begin
                    chk_bad = 1'b1;
                end
                chk_last = bmp.group_idx[j];
                chk_seen = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // bitmap and tracker registers
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bmp.bitmap      <= '0;
            bmp.order_error <= 1'b0;
            last_idx        <= '0;
            last_seen       <= 1'b0;
        end else if (zeroize || bmp.poly_start) begin
            // a new polynomial starts from an empty hint vector
            bmp.bitmap      <= '0;
            bmp.order_error <= 1'b0;
            last_idx        <= '0;
            last_seen       <= 1'b0;
        end else if (bmp.group_valid) begin
            bmp.bitmap <= bmp.bitmap | set_vec;
            last_idx   <= chk_last;
            last_seen  <= chk_seen;
            // the error is sticky until the next polynomial
            bmp.order_error <= bmp.order_error | chk_bad;
        end
    end

endmodule

/* hint_wb_writer.sv */
/*
 * hint Wishbone writer
 * writes the finished bitmap of one polynomial as 64 words of four
 * 24 bit coefficients, one Wishbone classic write per bus cycle
 */

module hint_wb_writer import hint_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          zeroize,
    hint_seq_if.writer    wr,
    input  logic          wb_ack,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output mem_addr_t     wb_adr,
    output mem_word_t     wb_dat
);

    // a write pass is running
    logic       active;

    // a bus cycle is open and waiting for its ack
    logic       bus_req;

    // word number inside the polynomial
    logic [5:0] word_cnt;

    mem_addr_t  base_addr;
    mem_word_t  word_data;
    logic       launch;
    logic       last_word;

    // ------------------------------------------------------------------
    // word packing
    // ------------------------------------------------------------------

    // word w holds bitmap bits 4w to 4w+3, each widened to a full coefficient
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            word_data[j*coeff_width +: coeff_width] =
                coeff_width'(wr.bitmap[{word_cnt, 2'(j)}]);
        end
    end

    // a new bus cycle opens one cycle after the previous one closed
    assign launch    = active && !bus_req;
    assign last_word = (word_cnt == 6'(words_per_poly - 1));

    // write-only master, so cyc, stb and we always move together
    assign wb_cyc = bus_req;
    assign wb_stb = bus_req;
    assign wb_we  = bus_req;

    // ------------------------------------------------------------------
    // pass control
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active        <= 1'b0;
            bus_req       <= 1'b0;
            word_cnt      <= '0;
            wr.write_done <= 1'b0;
        end else if (zeroize) begin
            active        <= 1'b0;
            bus_req       <= 1'b0;
            word_cnt      <= '0;
            wr.write_done <= 1'b0;
        end else begin
            wr.write_done <= 1'b0;
            if (wr.write_go) begin
                active   <= 1'b1;
                word_cnt <= '0;
            end else if (bus_req) begin
                // the bus drops the cycle after the ack is seen
                if (wb_ack) begin
                    bus_req <= 1'b0;
                    if (last_word) begin
                        active        <= 1'b0;
                        wr.write_done <= 1'b1;
                    end else begin
                        word_cnt <= word_cnt + 6'd1;
                    end
                end
            end else if (launch) begin
                bus_req <= 1'b1;
            end
        end
    end

    // address and data only change when a cycle opens, so they hold while stb waits
    always_ff @(posedge clk) begin
        if (wr.write_go) begin
            base_addr <= wr.write_base;
        end
        if (launch) begin
            wb_adr <= base_addr + mem_addr_t'(word_cnt);
            wb_dat <= word_data;
        end
    end

endmodule

/* sigdecode_h_top.sv */
/*
 * signature hint decode top
 * sequencer, bitmap builder and Wishbone writer joined by one interface
 */

module sigdecode_h_top import hint_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      start,
    input  logic [8*hint_bytes-1:0]   encoded_h,
    input  mem_addr_t                 dest_base_addr,
    input  logic                      wb_ack,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output mem_addr_t                 wb_adr,
    output mem_word_t                 wb_dat,
    output logic                      done,
    output logic                      error
);

    // ------------------------------------------------------------------
    // internal link between the three stages
    // ------------------------------------------------------------------

    hint_seq_if seq_if ();

    // decode walks counts and index bytes, the flat input maps byte i to bits 8i+7:8i
    hint_sequencer hint_sequencer_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .encoded_h      (encoded_h),
        .dest_base_addr (dest_base_addr),
        .seq            (seq_if.seq),
        .done           (done),
        .error          (error)
    );

    // execute builds the hint vector of the current polynomial
    hint_bitmap hint_bitmap_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .bmp     (seq_if.builder)
    );

    // result stores the hint vector through the Wishbone bus
    hint_wb_writer hint_wb_writer_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .wr      (seq_if.writer),
        .wb_ack  (wb_ack),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat  (wb_dat)
    );

endmodule

/* sigdecode_h_asserts.sv */
/*
 * hint decode bus assertions
 * Wishbone classic rules and done/error behavior of the decode top
 */

module sigdecode_h_asserts import hint_pkg::*; (
    input logic      clk,
    input logic      reset_n,
    input logic      zeroize,
    input logic      wb_cyc,
    input logic      wb_stb,
    input logic      wb_we,
    input logic      wb_ack,
    input mem_addr_t wb_adr,
    input mem_word_t wb_dat,
    input logic      done,
    input logic      error
);

    // write-only master, so the strobe never appears outside a write cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb |-> (wb_cyc && wb_we))
        else $error("wb_stb high without wb_cyc and wb_we");

    // a waiting strobe keeps address and data, zeroize may cut the cycle
    hold_while_wait: assert property (@(posedge clk) disable iff (!reset_n)
        (wb_stb && !wb_ack && !zeroize) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat)))
        else $error("Wishbone request changed before its ack");

    done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    // error only rises at the end of an operation
    error_with_done: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(error) |-> done)
        else $error("error rose without done");

    quiet_in_reset: assert property (@(posedge clk)
        !reset_n |-> (!wb_cyc && !wb_stb && !wb_we && !done && !error))
        else $error("bus or status active during reset");

    quiet_after_zeroize: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize |=> (!wb_cyc && !wb_stb && !done && !error))
        else $error("bus or status active after zeroize");

endmodule

bind sigdecode_h_top sigdecode_h_asserts sigdecode_h_asserts_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (zeroize),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_ack  (wb_ack),
    .wb_adr  (wb_adr),
    .wb_dat  (wb_dat),
    .done    (done),
    .error   (error)
);

/* tb_sigdecode_h.sv */
/*
 * testbench for the signature hint decode top
 * applies a table of hint encodings, answers the Wishbone writes from a
 * memory model and checks memory contents, write counts and the error flag
 */

module tb_sigdecode_h import hint_pkg::*; ();

    // ------------------------------------------------------------------
    // case table layout
    // ------------------------------------------------------------------

    localparam logic [2:0] k_none    = 3'd0;
    localparam logic [2:0] k_cnt_dec = 3'd1;
    localparam logic [2:0] k_cnt_big = 3'd2;
    localparam logic [2:0] k_dup     = 3'd3;
    localparam logic [2:0] k_swap    = 3'd4;

    localparam int n_cases      = 9;
    localparam int done_timeout = 20000;
    localparam int quiet_cycles = 200;
    localparam int poly_words   = hint_k * words_per_poly;

    // hints per polynomial, polynomial 0 in the low byte
    localparam logic [7:0][7:0] spread = {8'd4, 8'd1, 8'd9, 8'd2, 8'd7, 8'd0, 8'd5, 8'd3};

    typedef struct packed {
        logic [7:0][7:0] nh;
        logic [7:0]      step;
        logic [2:0]      kind;
        logic [2:0]      cpoly;
        logic            rand_ack;
        logic [7:0]      zero_after;
        mem_addr_t       base;
        logic            exp_err;
    } case_t;

    // ------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------

    logic                    clk = 1'b0;
    logic                    reset_n;
    logic                    zeroize;
    logic                    start;
    logic [8*hint_bytes-1:0] encoded_h;
    mem_addr_t               dest_base_addr;
    logic                    wb_ack = 1'b0;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    mem_addr_t               wb_adr;
    mem_word_t               wb_dat;
    logic                    done;
    logic                    error;

    // memory model state, one slot per word of the 8 polynomial window
    mem_word_t   mem [poly_words];
    int          wr_cnt [poly_words];
    int          wr_total = 0;
    int          bus_errors = 0;
    logic [1:0]  ack_wait = 2'd0;
    logic [31:0] rng = 32'he958_fed1;
    logic        rand_ack = 1'b0;

    // test state
    case_t                   cases [n_cases];
    bitmap_t                 exp_bmp [hint_k];
    logic [8*hint_bytes-1:0] enc;
    int                      errors = 0;
    int                      checks = 0;
    logic                    timed_out = 1'b0;

    always #4 clk = ~clk;

    sigdecode_h_top sigdecode_h_top_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .encoded_h      (encoded_h),
        .dest_base_addr (dest_base_addr),
        .wb_ack         (wb_ack),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat         (wb_dat),
        .done           (done),
        .error          (error)
    );

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // words that are never written keep a pattern built from their full address
    function automatic mem_word_t fill_word(input mem_addr_t a);
        return {6{2'b10, a}};
    endfunction

    // word w carries hint bits 4w to 4w+3, each as a coefficient of 1 or 0
    function automatic mem_word_t pack_word(input bitmap_t bmp, input int w);
        mem_word_t word;
        word = '0;
        for (int j = 0; j < 4; j++) begin
            word[j*coeff_width] = bmp[4*w + j];
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [95:0] exp,
                               input logic [95:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------------
    // Wishbone memory model
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        mem_addr_t   off;
        logic [31:0] r;
        // a new operation refills the window and clears the write counters
        if (start) begin
            for (int i = 0; i < poly_words; i++) begin
                mem[i]    <= fill_word(dest_base_addr + mem_addr_t'(i));
                wr_cnt[i] <= 0;
            end
            wr_total <= 0;
        end
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb && wb_we) begin
            if (ack_wait != 2'd0) begin
                ack_wait <= ack_wait - 2'd1;
            end else begin
                off = wb_adr - dest_base_addr;
                if (off < 14'd512) begin
                    mem[off[8:0]]    <= wb_dat;
                    wr_cnt[off[8:0]] <= wr_cnt[off[8:0]] + 1;
                end else begin
                    bus_errors++;
                    $display("write to address %h lies outside the destination window", wb_adr);
                end
                wr_total <= wr_total + 1;
                wb_ack   <= 1'b1;
                // wait cycles of 0 to 3 before the next ack
                r = next_rand(rng);
                rng      <= r;
                ack_wait <= rand_ack ? r[1:0] : 2'd0;
            end
        end
    end

    // ------------------------------------------------------------------
    // case building and checking
    // ------------------------------------------------------------------

    // hint i of polynomial p sits at index 3p + i*step, then one corruption is applied
    task automatic build_case(input case_t c);
        int    pos;
        int    idx;
        int    cb;
        int    fb;
        int    first [hint_k];
        byte_t tmp;
        enc = '0;
        pos = 0;
        for (int p = 0; p < hint_k; p++) begin
            exp_bmp[p] = '0;
            first[p]   = pos;
            for (int i = 0; i < int'(c.nh[p]); i++) begin
                idx = 3 * p + i * int'(c.step);
                enc[8*(pos+i) +: 8] = byte_t'(idx);
                exp_bmp[p][idx]     = 1'b1;
            end
            pos += int'(c.nh[p]);
            enc[8*(hint_omega+p) +: 8] = byte_t'(pos);
        end
        cb = 8 * (hint_omega + int'(c.cpoly));
        fb = 8 * first[c.cpoly];
        case (c.kind)
            k_cnt_dec: enc[cb +: 8] = enc[cb-8 +: 8] - 8'd1;
            k_cnt_big: enc[8*(hint_omega+hint_k-1) +: 8] = 8'd80;
            k_dup:     enc[fb+8 +: 8] = enc[fb +: 8];
            k_swap: begin
                // lanes 3 and 4 straddle a group boundary
                tmp               = enc[fb+24 +: 8];
                enc[fb+24 +: 8]   = enc[fb+32 +: 8];
                enc[fb+32 +: 8]   = tmp;
            end
            default: ;
        endcase
    endtask

    task automatic wait_done(output logic got, output logic err_at_done);
        int t;
        got         = 1'b0;
        err_at_done = 1'b0;
        t           = 0;
        while (!got && t < done_timeout) begin
            @(posedge clk);
            t++;
            if (done) begin
                got         = 1'b1;
                err_at_done = error;
            end
        end
    endtask

    // polynomials below the corrupted one are written once, the rest keep the fill
    task automatic compare_memory(input case_t c);
        int        n_ok;
        int        exp_cnt;
        mem_word_t exp_word;
        mem_addr_t a;
        n_ok = (c.kind == k_none) ? hint_k : int'(c.cpoly);
        for (int off = 0; off < poly_words; off++) begin
            a = c.base + mem_addr_t'(off);
            if (off / words_per_poly < n_ok) begin
                exp_word = pack_word(exp_bmp[off / words_per_poly], off % words_per_poly);
                exp_cnt  = 1;
            end else begin
                exp_word = fill_word(a);
                exp_cnt  = 0;
            end
            check_value($sformatf("mem[%h]", a), exp_word, mem[off]);
            check_value($sformatf("write_count[%h]", a), 96'(exp_cnt), 96'(wr_cnt[off]));
        end
    endtask

    // zeroize after some writes, then the bus must stay quiet with done and error low
    task automatic abort_case(input case_t c);
        int t;
        int snap;
        t = 0;
        while (wr_total < int'(c.zero_after) && t < done_timeout) begin
            @(posedge clk);
            t++;
        end
        if (t >= done_timeout) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout while waiting for writes before zeroize");
        end else begin
            zeroize <= 1'b1;
            @(posedge clk);
            zeroize <= 1'b0;
            @(posedge clk);
            snap = wr_total;
            for (int i = 0; i < quiet_cycles; i++) begin
                @(posedge clk);
                check_value("done", 96'(0), 96'(done));
                check_value("error", 96'(0), 96'(error));
                check_value("write_total", 96'(snap), 96'(wr_total));
            end
        end
    endtask

    task automatic run_case(input int n);
        case_t c;
        logic  got_done;
        logic  err_seen;
        c = cases[n];
        build_case(c);
        @(posedge clk);
        encoded_h      <= enc;
        dest_base_addr <= c.base;
        rand_ack       <= c.rand_ack;
        start          <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (c.zero_after != 8'd0) begin
            abort_case(c);
        end else begin
            wait_done(got_done, err_seen);
            if (!got_done) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout while waiting for done in case %0d", n);
            end else begin
                check_value("error", 96'(c.exp_err), 96'(err_seen));
                compare_memory(c);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        reset_n        = 1'b0;
        zeroize        = 1'b0;
        start          = 1'b0;
        encoded_h      = '0;
        dest_base_addr = '0;

        // hints, step, kind, poly, random ack, zeroize after, base, error
        cases[0] = {spread, 8'd27, k_none,    3'd0, 1'b0, 8'd0,  14'h0100, 1'b0};
        cases[1] = {64'd0,  8'd27, k_none,    3'd0, 1'b0, 8'd0,  14'h1000, 1'b0};
        cases[2] = {spread, 8'd27, k_none,    3'd0, 1'b1, 8'd0,  14'h0100, 1'b0};
        cases[3] = {spread, 8'd27, k_cnt_dec, 3'd3, 1'b1, 8'd0,  14'h0200, 1'b1};
        cases[4] = {spread, 8'd27, k_cnt_big, 3'd7, 1'b0, 8'd0,  14'h0300, 1'b1};
        cases[5] = {spread, 8'd13, k_dup,     3'd1, 1'b1, 8'd0,  14'h0400, 1'b1};
        cases[6] = {spread, 8'd13, k_swap,    3'd3, 1'b0, 8'd0,  14'h0500, 1'b1};
        cases[7] = {spread, 8'd27, k_none,    3'd0, 1'b1, 8'd20, 14'h0600, 1'b0};
        cases[8] = {spread, 8'd13, k_none,    3'd0, 1'b1, 8'd0,  14'h2345, 1'b0};

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        for (int n = 0; n < n_cases && !timed_out; n++) begin
            run_case(n);
        end

        $display("checks %0d, errors %0d, bus errors %0d", checks, errors, bus_errors);
        if (errors == 0 && bus_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
hint_pkg.sv
hint_seq_if.sv
hint_sequencer.sv
hint_bitmap.sv
hint_wb_writer.sv
sigdecode_h_top.sv
sigdecode_h_asserts.sv
tb_sigdecode_h.sv

/* run.sh */
#!/bin/sh
# build the hint decode testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sigdecode_h -f sim.f -o tb_sigdecode_h

# the simulation log is kept for inspection
./obj_dir/tb_sigdecode_h > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    exit 0
fi
exit 1
